//--- verilog/ahb_input_stage_defines.svh
`ifndef AHB_INPUT_STAGE_DEFINES_SVH
`define AHB_INPUT_STAGE_DEFINES_SVH

// ----------------------------------------------------------
// Field widths
// ----------------------------------------------------------

`define AHB_ADDR_W        32      // Byte address width
`define WRAP_OFS_W        4       // Beat index in a 16-beat window

// ----------------------------------------------------------
// HTRANS encoding
// ----------------------------------------------------------

`define AHB_TRANS_IDLE    2'b00   // No transfer
`define AHB_TRANS_BUSY    2'b01   // Master inserts a wait in a burst
`define AHB_TRANS_NONSEQ  2'b10   // First beat or single
`define AHB_TRANS_SEQ     2'b11   // Following beat of a burst

// ----------------------------------------------------------
// HBURST encoding
// ----------------------------------------------------------

`define AHB_BURST_SINGLE  3'b000
`define AHB_BURST_INCR    3'b001  // Undefined length
`define AHB_BURST_WRAP4   3'b010
`define AHB_BURST_INCR4   3'b011
`define AHB_BURST_WRAP8   3'b100
`define AHB_BURST_INCR8   3'b101
`define AHB_BURST_WRAP16  3'b110
`define AHB_BURST_INCR16  3'b111

// HRESP, only OKAY is generated locally
`define AHB_RESP_OKAY     2'b00

`endif

//--- verilog/ahb_input_stage_pkg.sv
`default_nettype none

`include "ahb_input_stage_defines.svh"

// ----------------------------------------------------------
// Types shared by the input stage
// ----------------------------------------------------------

package ahb_input_stage_pkg;

  // Byte address on HADDR
  typedef logic [`AHB_ADDR_W-1:0] haddr_t;

  // HTRANS field
  // IDLE, BUSY, NONSEQ or SEQ
  typedef logic [1:0] htrans_t;

  // HSIZE field
  // Bytes per beat as a power of two
  typedef logic [2:0] hsize_t;

  // HBURST field
  // Single, INCR, or fixed length wrap/incr
  typedef logic [2:0] hburst_t;

  // HRESP field
  typedef logic [1:0] hresp_t;

  // Beat index inside the widest wrap window
  // Address scaled down by transfer size
  typedef logic [`WRAP_OFS_W-1:0] wrap_ofs_t;

endpackage

`default_nettype wire

//--- verilog/ahb_hold_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "ahb_input_stage_defines.svh"

module ahb_hold_capture (
  input  wire                           HCLK,
  input  wire                           HRESETn,

  // Address phase from the input port
  input  wire                           HSELS,
  input  wire ahb_input_stage_pkg::haddr_t  HADDRS,
  input  wire ahb_input_stage_pkg::htrans_t HTRANSS,
  input  wire                           HWRITES,
  input  wire ahb_input_stage_pkg::hsize_t  HSIZES,
  input  wire ahb_input_stage_pkg::hburst_t HBURSTS,
  input  wire                           HREADYS,

  // Status from the output stage
  input  wire                           active_ip,
  input  wire                           readyout_ip,

  output logic                          load_reg,      // Capture strobe
  output logic                          pend_tran_reg, // Transfer waiting in holding reg
  output logic                          data_valid,    // Valid data phase in progress

  // Holding register
  output ahb_input_stage_pkg::haddr_t   reg_addr,
  output ahb_input_stage_pkg::htrans_t  reg_trans,
  output logic                          reg_write,
  output ahb_input_stage_pkg::hsize_t   reg_size,
  output ahb_input_stage_pkg::hburst_t  reg_burst
);

  logic addr_valid;   // Selected NONSEQ or SEQ in address phase

  // ----------------------------------------------------------
  // Load strobe
  // ----------------------------------------------------------

  assign addr_valid = HSELS & HTRANSS[1];  // BUSY and IDLE never load
  assign load_reg   = addr_valid & HREADYS; // Only when address phase completes

  // ----------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------

  // Captured every accepted address phase,
  // only read back while pend_tran_reg is set
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr  <= HADDRS;
      reg_trans <= HTRANSS;   // Original type, used for burst rewrite
      reg_write <= HWRITES;
      reg_size  <= HSIZES;
      reg_burst <= HBURSTS;
    end
  end

  // ----------------------------------------------------------
  // Pending flag
  // ----------------------------------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else if (load_reg && !active_ip)
      pend_tran_reg <= 1'b1;        // Output stage busy elsewhere
    else if (active_ip && readyout_ip)
      pend_tran_reg <= 1'b0;        // Held transfer accepted downstream
  end

  // ----------------------------------------------------------
  // Data phase tracking
  // ----------------------------------------------------------

  // Follows the address phase one cycle later
  // Frozen while the bus is stalled
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

endmodule

`default_nettype wire

//--- verilog/ahb_wrap_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "ahb_input_stage_defines.svh"

module ahb_wrap_tracker (
  input  wire                           HCLK,
  input  wire                           HRESETn,
  input  wire ahb_input_stage_pkg::haddr_t  HADDRS,
  input  wire ahb_input_stage_pkg::htrans_t HTRANSS,
  input  wire ahb_input_stage_pkg::hsize_t  HSIZES,
  input  wire ahb_input_stage_pkg::hburst_t HBURSTS,
  input  wire                           HREADYS,
  input  wire                           load_reg,       // From hold capture
  input  wire                           active_ip,
  output logic                          burst_override, // Burst was broken up
  output logic                          bound           // Last beat of wrap window seen
);

  import ahb_input_stage_pkg::*;

  wrap_ofs_t offset_addr;   // Address in beats
  wrap_ofs_t check_addr;    // Beat index with unused upper bits forced
  logic      bound_next;
  logic      override_next;

  // ----------------------------------------------------------
  // Burst override
  // ----------------------------------------------------------

  always_comb
  begin
    override_next = burst_override;
    case (HTRANSS)
      `AHB_TRANS_IDLE,
      `AHB_TRANS_NONSEQ : override_next = 1'b0;   // New burst or none
      `AHB_TRANS_SEQ    : if (load_reg && !active_ip)
                            override_next = 1'b1; // Burst interrupted
      `AHB_TRANS_BUSY   : override_next = burst_override;
      default           : override_next = burst_override;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= override_next;
  end

  // ----------------------------------------------------------
  // Wrap boundary detection
  // ----------------------------------------------------------

  always_comb
  begin
    case (HSIZES)
      3'b001  : offset_addr = HADDRS[4:1];  // Halfword
      3'b010  : offset_addr = HADDRS[5:2];  // Word
      3'b011  : offset_addr = HADDRS[6:3];  // Doubleword
      default : offset_addr = HADDRS[3:0];  // Byte, and wider sizes as bytes
    endcase
  end

  always_comb
  begin
    case (HBURSTS)
      `AHB_BURST_WRAP4  : check_addr = {2'b11, offset_addr[1:0]};
      `AHB_BURST_WRAP8  : check_addr = {1'b1, offset_addr[2:0]};
      `AHB_BURST_WRAP16 : check_addr = offset_addr;
      `AHB_BURST_SINGLE,
      `AHB_BURST_INCR,
      `AHB_BURST_INCR4,
      `AHB_BURST_INCR8,
      `AHB_BURST_INCR16 : check_addr = '0;   // No wrap to detect
      default           : check_addr = '0;
    endcase
  end

  assign bound_next = &check_addr;   // Index at end of window

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (HTRANSS[1] && HREADYS)  // Updated on accepted active beats
      bound <= bound_next;
  end

endmodule

`default_nettype wire

//--- verilog/ahb_output_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "ahb_input_stage_defines.svh"

module ahb_output_select (
  // Direct path
  input  wire                           HSELS,
  input  wire ahb_input_stage_pkg::haddr_t  HADDRS,
  input  wire ahb_input_stage_pkg::htrans_t HTRANSS,
  input  wire                           HWRITES,
  input  wire ahb_input_stage_pkg::hsize_t  HSIZES,
  input  wire ahb_input_stage_pkg::hburst_t HBURSTS,

  // Held path and status
  input  wire                           pend_tran_reg,
  input  wire                           data_valid,
  input  wire ahb_input_stage_pkg::haddr_t  reg_addr,
  input  wire ahb_input_stage_pkg::htrans_t reg_trans,
  input  wire                           reg_write,
  input  wire ahb_input_stage_pkg::hsize_t  reg_size,
  input  wire ahb_input_stage_pkg::hburst_t reg_burst,
  input  wire                           burst_override,
  input  wire                           bound,

  // Response from the output stage
  input  wire                           readyout_ip,
  input  wire ahb_input_stage_pkg::hresp_t  resp_ip,

  // To the output stage
  output logic                          sel_ip,
  output ahb_input_stage_pkg::haddr_t   addr_ip,
  output ahb_input_stage_pkg::htrans_t  trans_ip,
  output logic                          write_ip,
  output ahb_input_stage_pkg::hsize_t   size_ip,
  output ahb_input_stage_pkg::hburst_t  burst_ip,

  // Back to the input port
  output logic                          HREADYOUTS,
  output ahb_input_stage_pkg::hresp_t   HRESPS
);

  import ahb_input_stage_pkg::*;

  htrans_t trans_int;   // Selected type before wrap rewrite
  htrans_t transb;      // Original type of the selected transfer
  hburst_t burst_int;   // Selected burst before override

  // ----------------------------------------------------------
  // Direct or held path
  // ----------------------------------------------------------

  always_comb
  begin
    if (pend_tran_reg)
    begin
      sel_ip    = 1'b1;
      trans_int = `AHB_TRANS_NONSEQ;  // Held beat always restarts
      addr_ip   = reg_addr;
      write_ip  = reg_write;
      size_ip   = reg_size;
      burst_int = reg_burst;
      transb    = reg_trans;
    end
    else
    begin
      sel_ip    = HSELS;
      trans_int = HTRANSS;
      addr_ip   = HADDRS;
      write_ip  = HWRITES;
      size_ip   = HSIZES;
      burst_int = HBURSTS;
      transb    = HTRANSS;
    end
  end

  // SEQ to NONSEQ, BUSY to IDLE past the wrap point
  assign trans_ip = (burst_override && bound) ? {trans_int[1], 1'b0} : trans_int;

  // Rest of a broken burst goes out as INCR
  assign burst_ip = (burst_override && (transb != `AHB_TRANS_NONSEQ)) ?
                    `AHB_BURST_INCR : burst_int;

  // ----------------------------------------------------------
  // Response source
  // ----------------------------------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;            // Unselected, IDLE or BUSY
      HRESPS     = `AHB_RESP_OKAY;
    end
    else if (pend_tran_reg)
    begin
      HREADYOUTS = 1'b0;            // Stall while held
      HRESPS     = `AHB_RESP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ahb_input_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_input_stage (
  input  wire                           HCLK,
  input  wire                           HRESETn,

  // Input port address phase
  input  wire                           HSELS,
  input  wire ahb_input_stage_pkg::haddr_t  HADDRS,
  input  wire ahb_input_stage_pkg::htrans_t HTRANSS,
  input  wire                           HWRITES,
  input  wire ahb_input_stage_pkg::hsize_t  HSIZES,
  input  wire ahb_input_stage_pkg::hburst_t HBURSTS,
  input  wire                           HREADYS,

  // Internal response
  input  wire                           active_ip,   // Output stage serving this port
  input  wire                           readyout_ip,
  input  wire ahb_input_stage_pkg::hresp_t  resp_ip,

  // Input port response
  output logic                          HREADYOUTS,
  output ahb_input_stage_pkg::hresp_t   HRESPS,

  // To the output stage
  output logic                          sel_ip,
  output ahb_input_stage_pkg::haddr_t   addr_ip,
  output ahb_input_stage_pkg::htrans_t  trans_ip,
  output logic                          write_ip,
  output ahb_input_stage_pkg::hsize_t   size_ip,
  output ahb_input_stage_pkg::hburst_t  burst_ip,
  output logic                          held_tran_ip  // Request to the arbiter
);

  import ahb_input_stage_pkg::*;

  logic    load_reg;
  logic    pend_tran_reg;
  logic    data_valid;
  haddr_t  reg_addr;
  htrans_t reg_trans;
  logic    reg_write;
  hsize_t  reg_size;
  hburst_t reg_burst;
  logic    burst_override;
  logic    bound;

  // ----------------------------------------------------------
  // Capture, boundary tracking, output selection
  // ----------------------------------------------------------

  ahb_hold_capture u_capture (
    .HCLK, .HRESETn,
    .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS, .HREADYS,
    .active_ip, .readyout_ip,
    .load_reg, .pend_tran_reg, .data_valid,
    .reg_addr, .reg_trans, .reg_write, .reg_size, .reg_burst
  );

  ahb_wrap_tracker u_wrap (
    .HCLK, .HRESETn,
    .HADDRS, .HTRANSS, .HSIZES, .HBURSTS, .HREADYS,
    .load_reg, .active_ip,
    .burst_override, .bound
  );

  ahb_output_select u_select (
    .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS,
    .pend_tran_reg, .data_valid,
    .reg_addr, .reg_trans, .reg_write, .reg_size, .reg_burst,
    .burst_override, .bound,
    .readyout_ip, .resp_ip,
    .sel_ip, .addr_ip, .trans_ip, .write_ip, .size_ip, .burst_ip,
    .HREADYOUTS, .HRESPS
  );

  // Request on a new load, kept up while held
  assign held_tran_ip = load_reg | pend_tran_reg;

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic HCLK,
  output logic HRESETn
);

  // 20 ns period
  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Low for the first two rising edges
  initial
  begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #2;                  // Off the edge, same as the stimulus
    HRESETn = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/ahb_input_stage_sva.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_input_stage_sva (
  input wire HCLK,
  input wire HRESETn,
  input wire load_reg,
  input wire pend_tran_reg,
  input wire active_ip
);

  int assert_failures = 0;   // Failure count, polled by the testbench

  // ------------------------------------------------------------
  // Hold protocol
  // ------------------------------------------------------------

  // Output stage elsewhere, so the loaded beat must wait
  property p_hold_after_load;
    @(posedge HCLK) disable iff (!HRESETn)
      load_reg && !active_ip |=> pend_tran_reg;
  endproperty

  property p_no_rise_without_load;
    @(posedge HCLK) disable iff (!HRESETn)
      $rose(pend_tran_reg) |-> $past(load_reg);
  endproperty

  // HREADYS is low for the whole hold
  property p_no_load_while_held;
    @(posedge HCLK) disable iff (!HRESETn)
      pend_tran_reg |-> !load_reg;
  endproperty

  a_hold_after_load : assert property (p_hold_after_load)
  else
  begin
    $error("Load with active_ip low was not held");
    assert_failures++;
  end

  a_no_rise_without_load : assert property (p_no_rise_without_load)
  else
  begin
    $error("pend_tran_reg rose without a load");
    assert_failures++;
  end

  a_no_load_while_held : assert property (p_no_load_while_held)
  else
  begin
    $error("Transfer loaded while another was held");
    assert_failures++;
  end

endmodule

bind ahb_hold_capture ahb_input_stage_sva u_hold_sva (
  .HCLK          (HCLK),
  .HRESETn       (HRESETn),
  .load_reg      (load_reg),
  .pend_tran_reg (pend_tran_reg),
  .active_ip     (active_ip)
);

`default_nettype wire

//--- bench/ahb_input_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ahb_input_stage_defines.svh"

module ahb_input_stage_tb;

  import ahb_input_stage_pkg::*;

  wire     HCLK;
  wire     HRESETn;

  logic    HSELS;        // DUT inputs
  haddr_t  HADDRS;
  htrans_t HTRANSS;
  logic    HWRITES;
  hsize_t  HSIZES;
  hburst_t HBURSTS;
  logic    HREADYS;
  logic    active_ip;
  logic    readyout_ip;
  hresp_t  resp_ip;

  logic    HREADYOUTS;   // DUT outputs
  hresp_t  HRESPS;
  logic    sel_ip;
  haddr_t  addr_ip;
  htrans_t trans_ip;
  logic    write_ip;
  hsize_t  size_ip;
  hburst_t burst_ip;
  logic    held_tran_ip;

  // Values for the next drive
  logic    nx_sel;
  haddr_t  nx_addr;
  htrans_t nx_trans;
  logic    nx_write;
  hsize_t  nx_size;
  hburst_t nx_burst;
  logic    nx_ready;
  logic    nx_active;
  logic    nx_readyout;
  hresp_t  nx_resp;

  // Reference model state
  logic    m_pend;
  logic    m_dv;
  logic    m_ovr;
  logic    m_bound;
  haddr_t  m_addr;
  htrans_t m_trans;
  logic    m_write;
  hsize_t  m_size;
  hburst_t m_burst;

  logic [31:0] lcg_state = 32'h006d_25f7;

  tb_clock_gen u_clk (.HCLK(HCLK), .HRESETn(HRESETn));

  ahb_input_stage dut (
    .HCLK, .HRESETn,
    .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS, .HREADYS,
    .active_ip, .readyout_ip, .resp_ip,
    .HREADYOUTS, .HRESPS,
    .sel_ip, .addr_ip, .trans_ip, .write_ip, .size_ip, .burst_ip, .held_tran_ip
  );

  // ------------------------------------------------------------
  // Random numbers and failure reporting
  // ------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_failure(string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_addr(string name, haddr_t got, haddr_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_trans(string name, htrans_t got, htrans_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_size(string name, hsize_t got, hsize_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_burst(string name, hburst_t got, hburst_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_resp(string name, hresp_t got, hresp_t exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Last beat of its wrap window
  // Sizes above 64 bits count as bytes
  function automatic logic wrap_last_beat(haddr_t addr, hsize_t size, hburst_t burst);
    logic [3:0] idx;
    idx = (size <= 3'd3) ? 4'(addr >> size) : addr[3:0];
    case (burst)
      `AHB_BURST_WRAP4  : return idx[1:0] == 2'b11;
      `AHB_BURST_WRAP8  : return idx[2:0] == 3'b111;
      `AHB_BURST_WRAP16 : return idx == 4'hf;
      default           : return 1'b0;
    endcase
  endfunction

  // Inputs still hold the values of the ending cycle
  task automatic update_model();
    logic load;
    load = HSELS & HTRANSS[1] & HREADYS;
    if (load)
    begin
      m_addr  = HADDRS;
      m_trans = HTRANSS;
      m_write = HWRITES;
      m_size  = HSIZES;
      m_burst = HBURSTS;
    end
    if (!HRESETn)
    begin
      m_pend  = 1'b0;
      m_dv    = 1'b0;
      m_ovr   = 1'b0;
      m_bound = 1'b0;
    end
    else
    begin
      if (load && !active_ip)
        m_pend = 1'b1;
      else if (active_ip && readyout_ip)
        m_pend = 1'b0;
      if (HREADYS)
      begin
        m_dv = HSELS & HTRANSS[1];
        if (HTRANSS == `AHB_TRANS_NONSEQ || HTRANSS == `AHB_TRANS_IDLE)
          m_ovr = 1'b0;
        else if (HTRANSS == `AHB_TRANS_SEQ && load && !active_ip)
          m_ovr = 1'b1;       // Burst broken off
        if (HTRANSS[1])
          m_bound = wrap_last_beat(HADDRS, HSIZES, HBURSTS);
      end
    end
  endtask

  task automatic check_outputs();
    logic    exp_sel;
    haddr_t  exp_addr;
    htrans_t exp_trans;
    htrans_t orig_trans;
    logic    exp_write;
    hsize_t  exp_size;
    hburst_t exp_burst;
    logic    exp_ready;
    hresp_t  exp_resp;
    if (m_pend)
    begin
      exp_sel    = 1'b1;
      exp_trans  = `AHB_TRANS_NONSEQ;
      orig_trans = m_trans;
      exp_addr   = m_addr;
      exp_write  = m_write;
      exp_size   = m_size;
      exp_burst  = m_burst;
    end
    else
    begin
      exp_sel    = HSELS;
      exp_trans  = HTRANSS;
      orig_trans = HTRANSS;
      exp_addr   = HADDRS;
      exp_write  = HWRITES;
      exp_size   = HSIZES;
      exp_burst  = HBURSTS;
    end
    if (m_ovr && m_bound)
      exp_trans[0] = 1'b0;    // SEQ as NONSEQ, BUSY as IDLE
    if (m_ovr && orig_trans != `AHB_TRANS_NONSEQ)
      exp_burst = `AHB_BURST_INCR;
    exp_ready = m_dv ? (!m_pend && readyout_ip) : 1'b1;
    exp_resp  = (m_dv && !m_pend) ? resp_ip : `AHB_RESP_OKAY;
    check_bit("sel_ip", sel_ip, exp_sel);
    check_addr("addr_ip", addr_ip, exp_addr);
    check_trans("trans_ip", trans_ip, exp_trans);
    check_bit("write_ip", write_ip, exp_write);
    check_size("size_ip", size_ip, exp_size);
    check_burst("burst_ip", burst_ip, exp_burst);
    check_bit("HREADYOUTS", HREADYOUTS, exp_ready);
    check_resp("HRESPS", HRESPS, exp_resp);
    check_bit("held_tran_ip", held_tran_ip, (HSELS & HTRANSS[1] & HREADYS) | m_pend);
    if (dut.u_capture.u_hold_sva.assert_failures != 0)
      report_failure("A hold protocol assertion failed");
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Edge, model update, drive 2 ns later, compare at the falling edge
  task automatic step_cycle();
    @(posedge HCLK);
    update_model();
    #2;
    HSELS       = nx_sel;
    HADDRS      = nx_addr;
    HTRANSS     = nx_trans;
    HWRITES     = nx_write;
    HSIZES      = nx_size;
    HBURSTS     = nx_burst;
    HREADYS     = m_pend ? 1'b0 : nx_ready;  // Held data phase stalls the bus
    active_ip   = nx_active;
    readyout_ip = nx_readyout;
    resp_ip     = nx_resp;
    @(negedge HCLK);
    check_outputs();
  endtask

  task automatic random_inputs(logic force_active);
    logic [31:0] r;
    r           = next_rand();
    nx_sel      = r[31:30] != 2'b00;
    nx_trans    = r[29:28];
    nx_write    = r[27];
    nx_size     = r[26:24];
    nx_burst    = r[23:21];
    nx_ready    = r[20:18] != 3'b000;
    nx_active   = force_active | (r[17:16] != 2'b00);
    nx_readyout = r[15:14] != 2'b00;
    nx_resp     = r[13:12];
    nx_addr     = next_rand();
  endtask

  task automatic set_idle();
    nx_sel      = 1'b0;
    nx_trans    = `AHB_TRANS_IDLE;
    nx_ready    = 1'b1;
    nx_active   = 1'b1;
    nx_readyout = 1'b1;
    nx_resp     = `AHB_RESP_OKAY;
  endtask

  task automatic set_beat(htrans_t trans, haddr_t addr, hsize_t size, hburst_t burst);
    nx_sel      = 1'b1;
    nx_trans    = trans;
    nx_addr     = addr;
    nx_write    = 1'(next_rand() >> 31);
    nx_size     = size;
    nx_burst    = burst;
    nx_ready    = 1'b1;
    nx_active   = 1'b1;
    nx_readyout = 1'b1;
    nx_resp     = `AHB_RESP_OKAY;
  endtask

  task automatic wait_release();
    int waited;
    waited = 0;
    while (m_pend)
    begin
      nx_ready    = 1'b0;             // Master still in the stalled data phase
      nx_active   = 1'b1;
      nx_readyout = 1'(next_rand() >> 31);  // Random back-pressure
      step_cycle();
      waited++;
      if (waited > 100)
        report_failure("Held transfer was not released within 100 cycles");
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic hold_test();
    haddr_t  a;
    hsize_t  sz;
    hburst_t bu;
    logic    wr;
    wait_release();
    set_idle();
    step_cycle();                       // Clears any burst override
    a  = next_rand();
    sz = hsize_t'(next_rand() >> 29);
    bu = hburst_t'(next_rand() >> 29);
    set_beat(`AHB_TRANS_NONSEQ, a, sz, bu);
    nx_active = 1'b0;
    wr = nx_write;
    step_cycle();
    check_bit("held_tran_ip", held_tran_ip, 1'b1);
    set_idle();
    nx_active = 1'b0;
    step_cycle();                       // First held cycle
    check_bit("sel_ip", sel_ip, 1'b1);
    check_trans("trans_ip", trans_ip, `AHB_TRANS_NONSEQ);
    check_addr("addr_ip", addr_ip, a);
    check_bit("write_ip", write_ip, wr);
    check_size("size_ip", size_ip, sz);
    check_burst("burst_ip", burst_ip, bu);
    check_bit("HREADYOUTS", HREADYOUTS, 1'b0);
    check_resp("HRESPS", HRESPS, `AHB_RESP_OKAY);
    wait_release();
  endtask

  // Unselected, IDLE and BUSY phases answer ready and OKAY
  task automatic idle_test(logic sel, htrans_t trans);
    wait_release();
    set_beat(trans, next_rand(), 3'b010, `AHB_BURST_INCR);
    nx_sel = sel;
    step_cycle();
    set_idle();
    nx_readyout = 1'b0;
    nx_resp     = 2'b01;
    step_cycle();
    check_bit("HREADYOUTS", HREADYOUTS, 1'b1);
    check_resp("HRESPS", HRESPS, `AHB_RESP_OKAY);
  endtask

  task automatic wrap_test(hsize_t size, hburst_t burst);
    haddr_t     a;
    logic [3:0] last;
    last = (burst == `AHB_BURST_WRAP4) ? 4'h3 : (burst == `AHB_BURST_WRAP8) ? 4'h7 : 4'hf;
    wait_release();
    set_idle();
    step_cycle();
    set_beat(`AHB_TRANS_SEQ, next_rand(), size, burst);
    nx_active = 1'b0;                   // Interrupted burst
    step_cycle();
    nx_ready = 1'b0;
    step_cycle();
    wait_release();
    a = next_rand() | (haddr_t'(last) << ((size <= 3'd3) ? size : 3'd0));
    set_beat(`AHB_TRANS_SEQ, a, size, burst);
    step_cycle();                       // Beat at the end of the window
    set_beat(`AHB_TRANS_BUSY, a, size, burst);
    step_cycle();
    check_trans("trans_ip", trans_ip, `AHB_TRANS_IDLE);
    check_burst("burst_ip", burst_ip, `AHB_BURST_INCR);
    set_beat(`AHB_TRANS_SEQ, a, size, burst);
    step_cycle();
    check_trans("trans_ip", trans_ip, `AHB_TRANS_NONSEQ);
    check_burst("burst_ip", burst_ip, `AHB_BURST_INCR);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial
  begin
    int cycles;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = `AHB_TRANS_IDLE;
    HWRITES     = 1'b0;
    HSIZES      = '0;
    HBURSTS     = `AHB_BURST_SINGLE;
    HREADYS     = 1'b1;
    active_ip   = 1'b1;
    readyout_ip = 1'b1;
    resp_ip     = `AHB_RESP_OKAY;
    nx_addr     = '0;
    nx_write    = 1'b0;
    nx_size     = '0;
    nx_burst    = `AHB_BURST_SINGLE;
    set_idle();
    cycles = 0;
    while (HRESETn !== 1'b1)
    begin
      step_cycle();
      cycles++;
      if (cycles > 8)
        report_failure("Reset was not released within 8 cycles");
    end
    repeat (500)
    begin
      random_inputs(1'b1);              // Pass-through only
      step_cycle();
    end
    repeat (3000)
    begin
      random_inputs(1'b0);
      step_cycle();
    end
    repeat (20) hold_test();
    idle_test(1'b0, `AHB_TRANS_NONSEQ);
    idle_test(1'b1, `AHB_TRANS_IDLE);
    idle_test(1'b1, `AHB_TRANS_BUSY);
    for (int s = 0; s < 8; s++)
    begin
      wrap_test(hsize_t'(s), `AHB_BURST_WRAP4);
      wrap_test(hsize_t'(s), `AHB_BURST_WRAP8);
      wrap_test(hsize_t'(s), `AHB_BURST_WRAP16);
    end
    if (dut.u_capture.u_hold_sva.assert_failures == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      report_failure("A hold protocol assertion failed");
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/ahb_input_stage_pkg.sv
verilog/ahb_hold_capture.sv
verilog/ahb_wrap_tracker.sv
verilog/ahb_output_select.sv
verilog/ahb_input_stage.sv
bench/tb_clock_gen.sv
bench/ahb_input_stage_sva.sv
bench/ahb_input_stage_tb.sv

//--- Bender.yml
package:
  name: ahb_input_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ahb_input_stage_pkg.sv
      - verilog/ahb_hold_capture.sv
      - verilog/ahb_wrap_tracker.sv
      - verilog/ahb_output_select.sv
      - verilog/ahb_input_stage.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/tb_clock_gen.sv
      - bench/ahb_input_stage_sva.sv
      - bench/ahb_input_stage_tb.sv
